/* flist.f */
logic/conv_cfg_pkg.sv
logic/conv_types_pkg.sv
logic/tap_if.sv
logic/tap_sequencer.sv
logic/mac_lane.sv
logic/psum_reducer.sv
logic/conv_pe_top.sv
sim/conv_pe_tb.sv

/* Bender.yml */
package:
  name: conv_pe

sources:
  - files:
      - logic/conv_cfg_pkg.sv
      - logic/conv_types_pkg.sv
      - logic/tap_if.sv
      - logic/tap_sequencer.sv
      - logic/mac_lane.sv
      - logic/psum_reducer.sv
      - logic/conv_pe_top.sv
  - target: test
    files:
      - sim/conv_pe_tb.sv

/* sim/conv_pe_tb.sv */
`timescale 1ns/100ps

module conv_pe_tb;

    typedef enum logic [1:0] {
        BIAS_POS,
        BIAS_NEG,
        BIAS_MIX
    } bias_e;

    typedef struct packed {
        logic        load;      // load weights before the window
        logic [31:0] wseed;
        logic [31:0] aseed;
        logic [8:0]  stall;     // idle cycle before each flagged tap
        bias_e       bias;
    } row_t;

    localparam int NUM_ROWS = 8;
    localparam logic [31:0] LCG_SEED = 32'he58d_cf95;
    localparam int WATCHDOG_CYC =
        NUM_ROWS * (2 * conv_cfg_pkg::TAPS + 8 + conv_cfg_pkg::RESULT_LAT) + 50;

    logic                      clk;
    logic                      rst;
    logic                      wght_valid_i;
    conv_types_pkg::wght_vec_t wght_i;
    logic                      wght_ready_o;
    logic                      act_valid_i;
    conv_types_pkg::act_vec_t  act_i;
    logic                      act_ready_o;
    conv_types_pkg::acc_t      result_o;
    logic                      result_valid_o;

    row_t                      rows [NUM_ROWS];
    conv_types_pkg::wght_vec_t wts [conv_cfg_pkg::TAPS];   // model copy of weight memories
    int                        due_q [$];                   // cycle each result is due
    conv_types_pkg::acc_t      exp_q [$];
    int                        cyc = 0;
    int                        res_errs = 0;
    int                        flag_errs = 0;
    int                        proto_errs = 0;

    conv_pe_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .wght_valid_i   (wght_valid_i),
        .wght_i         (wght_i),
        .wght_ready_o   (wght_ready_o),
        .act_valid_i    (act_valid_i),
        .act_i          (act_i),
        .act_ready_o    (act_ready_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////
    // helpers

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic conv_types_pkg::wght_t make_wght(input logic [7:0] r, input bias_e b);
        case (b)
            BIAS_POS: return conv_types_pkg::wght_t'({1'b0, r[6:0]});
            BIAS_NEG: return conv_types_pkg::wght_t'({1'b1, r[6:0]});   // -128..-1
            default:  return conv_types_pkg::wght_t'(r);
        endcase
    endfunction

    task automatic check_result(input conv_types_pkg::acc_t got, input conv_types_pkg::acc_t exp);
        if (got !== exp) begin
            res_errs++;
            $display("ERROR @%0t: result_o got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errs++;
            $display("ERROR @%0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        wght_valid_i = 1'b0;
        act_valid_i = 1'b0;
    endtask

    // returns in the low phase of the accepting cycle
    task automatic push_wght(input conv_types_pkg::wght_vec_t wv);
        @(negedge clk);
        act_valid_i = 1'b0;
        wght_valid_i = 1'b1;
        wght_i = wv;
        #1;
        check_flag(wght_ready_o, 1'b1, "wght_ready_o");
        check_flag(act_ready_o, 1'b0, "act_ready_o");
        while (!wght_ready_o) begin
            @(negedge clk);
            #1;
        end
    endtask

    task automatic push_act(input conv_types_pkg::act_vec_t av, input int beat);
        @(negedge clk);
        wght_valid_i = 1'b0;
        act_valid_i = 1'b1;
        act_i = av;
        #1;
        check_flag(act_ready_o, 1'b1, "act_ready_o");
        check_flag(wght_ready_o, beat == 0, "wght_ready_o");   // open only at boundary
        while (!act_ready_o) begin
            @(negedge clk);
            #1;
        end
    endtask

    //////////////////////////////
    // result monitor
    initial begin
        @(negedge rst);
        forever begin
            @(negedge clk);
            if (due_q.size() > 0 && due_q[0] == cyc) begin
                check_flag(result_valid_o, 1'b1, "result_valid_o");
                if (result_valid_o) begin
                    check_result(result_o, exp_q[0]);
                end else begin
                    proto_errs++;
                    $display("window result did not arrive in cycle %0d", cyc);
                end
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end else begin
                check_flag(result_valid_o, 1'b0, "result_valid_o");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("CHECKS FAILED");
        $finish;
    end

    //////////////////////////////
    // stimulus
    initial begin
        logic [31:0]               s;
        conv_types_pkg::wght_vec_t wv;
        conv_types_pkg::act_vec_t  av;
        int                        sum;

        rst = 1'b1;
        wght_valid_i = 1'b0;
        wght_i = '0;
        act_valid_i = 1'b0;
        act_i = '0;

        rows[0] = '{1'b1, 32'h0000_0001, 32'h0000_0002, 9'h000, BIAS_POS};
        rows[1] = '{1'b0, 32'h0000_0000, 32'h0000_0003, 9'h000, BIAS_MIX};  // weights kept
        rows[2] = '{1'b1, 32'h0000_0004, 32'h0000_0005, 9'h000, BIAS_NEG};  // relu clamps
        rows[3] = '{1'b1, 32'h0000_0006, 32'h0000_0007, 9'h000, BIAS_MIX};
        rows[4] = '{1'b0, 32'h0000_0000, 32'h0000_0008, 9'h000, BIAS_MIX};
        rows[5] = '{1'b0, 32'h0000_0000, 32'h0000_0008, 9'h155, BIAS_MIX};  // same data, stalled
        rows[6] = '{1'b1, 32'h0000_0009, 32'h0000_000a, 9'h0ff, BIAS_POS};
        rows[7] = '{1'b1, 32'h0000_000b, 32'h0000_0008, 9'h000, BIAS_MIX};

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(wght_ready_o, 1'b1, "wght_ready_o after reset");
        check_flag(act_ready_o, 1'b0, "act_ready_o after reset");
        check_flag(result_valid_o, 1'b0, "result_valid_o after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].load) begin
                s = LCG_SEED ^ rows[r].wseed;
                for (int t = 0; t < conv_cfg_pkg::TAPS; t++) begin
                    for (int l = 0; l < conv_cfg_pkg::LANES; l++) begin
                        s = lcg_next(s);
                        wv[l] = make_wght(s[23:16], rows[r].bias);
                    end
                    wts[t] = wv;
                    push_wght(wv);
                end
            end
            // reference: sum of act x weight over taps and lanes
            s = LCG_SEED ^ rows[r].aseed;
            sum = 0;
            for (int t = 0; t < conv_cfg_pkg::TAPS; t++) begin
                for (int l = 0; l < conv_cfg_pkg::LANES; l++) begin
                    s = lcg_next(s);
                    av[l] = s[23:16];
                    sum += int'(av[l]) * int'(wts[t][l]);
                end
                if (rows[r].stall[t]) begin
                    idle_cycle();
                end
                push_act(av, t);
            end
            due_q.push_back(cyc + conv_cfg_pkg::RESULT_LAT);
            exp_q.push_back((sum < 0) ? '0 : conv_types_pkg::acc_t'(sum));
        end

        idle_cycle();
        repeat (conv_cfg_pkg::RESULT_LAT + 2) @(negedge clk);
        if (due_q.size() != 0) begin
            proto_errs++;
            $display("%0d window results never appeared", due_q.size());
        end

        $display("errors: result %0d, flag %0d, protocol %0d", res_errs, flag_errs, proto_errs);
        if (res_errs + flag_errs + proto_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* logic/conv_pe_top.sv */
`timescale 1ns/100ps

module conv_pe_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wght_valid_i,
    input  conv_types_pkg::wght_vec_t wght_i,
    output logic                      wght_ready_o,
    input  logic                      act_valid_i,
    input  conv_types_pkg::act_vec_t  act_i,
    output logic                      act_ready_o,
    output conv_types_pkg::acc_t      result_o,
    output logic                      result_valid_o
);

    conv_types_pkg::prod_vec_t        prod_vec;
    logic [conv_cfg_pkg::LANES-1:0]   lane_valid;
    logic [conv_cfg_pkg::LANES-1:0]   lane_last;

    tap_if u_tap_if ();

    tap_sequencer u_tap_sequencer (
        .clk          (clk),
        .rst          (rst),
        .wght_valid_i (wght_valid_i),
        .wght_i       (wght_i),
        .wght_ready_o (wght_ready_o),
        .act_valid_i  (act_valid_i),
        .act_i        (act_i),
        .act_ready_o  (act_ready_o),
        .tap          (u_tap_if.seq)
    );

    //////////////////////////////
    // channel lanes
    for (genvar g = 0; g < conv_cfg_pkg::LANES; g++) begin : g_lane
        mac_lane #(
            .lane_idx (g)
        ) u_mac_lane (
            .clk          (clk),
            .tap          (u_tap_if.lane),
            .prod_o       (prod_vec[g]),
            .prod_valid_o (lane_valid[g]),
            .prod_last_o  (lane_last[g])
        );
    end

    // lanes run in lockstep, lane 0 speaks for all
    psum_reducer u_psum_reducer (
        .clk            (clk),
        .rst            (rst),
        .prod_i         (prod_vec),
        .prod_valid_i   (lane_valid[0]),
        .prod_last_i    (lane_last[0]),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

endmodule

/* logic/psum_reducer.sv */
`timescale 1ns/100ps

module psum_reducer (
    input  logic                      clk,
    input  logic                      rst,
    input  conv_types_pkg::prod_vec_t prod_i,
    input  logic                      prod_valid_i,
    input  logic                      prod_last_i,
    output conv_types_pkg::acc_t      result_o,
    output logic                      result_valid_o
);

    conv_types_pkg::acc_t lvl1_q [conv_cfg_pkg::LANES/2];
    conv_types_pkg::acc_t lvl2_q [conv_cfg_pkg::LANES/4];
    conv_types_pkg::acc_t lvl3_q;
    conv_types_pkg::acc_t acc_q;
    conv_types_pkg::acc_t acc_sum;

    logic [conv_cfg_pkg::TREE_STAGES-1:0] vld_q;
    logic [conv_cfg_pkg::TREE_STAGES-1:0] last_q;
    logic                                 acc_fresh_q;  // next beat opens a window
    logic                                 tree_vld;
    logic                                 tree_last;

    //////////////////////////////
    // adder tree

    always_ff @(posedge clk) begin
        for (int i = 0; i < conv_cfg_pkg::LANES / 2; i++) begin
            lvl1_q[i] <= conv_types_pkg::acc_t'(prod_i[2*i])
                       + conv_types_pkg::acc_t'(prod_i[2*i+1]);
        end
        for (int i = 0; i < conv_cfg_pkg::LANES / 4; i++) begin
            lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
        end
        lvl3_q <= lvl2_q[0] + lvl2_q[1];
    end

    // valid and last ride alongside the tree
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
            last_q <= '0;
        end else begin
            vld_q <= {vld_q[conv_cfg_pkg::TREE_STAGES-2:0], prod_valid_i};
            last_q <= {last_q[conv_cfg_pkg::TREE_STAGES-2:0], prod_last_i};
        end
    end

    assign tree_vld = vld_q[conv_cfg_pkg::TREE_STAGES-1];
    assign tree_last = last_q[conv_cfg_pkg::TREE_STAGES-1];

    //////////////////////////////
    // window accumulate and ReLU

    assign acc_sum = (acc_fresh_q ? '0 : acc_q) + lvl3_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_fresh_q <= 1'b1;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= tree_vld && tree_last;
            if (tree_vld) begin
                acc_fresh_q <= tree_last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tree_vld) begin
            acc_q <= acc_sum;
        end
        if (tree_vld && tree_last) begin
            result_o <= acc_sum[conv_cfg_pkg::ACC_W-1] ? '0 : acc_sum;  // clamp negatives
        end
    end

endmodule

/* logic/mac_lane.sv */
`timescale 1ns/100ps

module mac_lane #(
    parameter int lane_idx = 0
) (
    input  logic                  clk,
    tap_if.lane                   tap,
    output conv_types_pkg::prod_t prod_o,
    output logic                  prod_valid_o,
    output logic                  prod_last_o
);

    conv_types_pkg::wght_t wght_mem [conv_cfg_pkg::TAPS];

    conv_types_pkg::wght_t wght_q;
    conv_types_pkg::act_t  act_q;
    logic                  rd_q;
    logic                  last_q;

    // weight store, one entry per tap
    always_ff @(posedge clk) begin
        if (tap.wr_en) begin
            wght_mem[tap.tap_addr] <= tap.wght[lane_idx];
        end
    end

    // stage 1: sync read, act lines up with it
    always_ff @(posedge clk) begin
        if (tap.rd_en) begin
            wght_q <= wght_mem[tap.tap_addr];
            act_q <= tap.act[lane_idx];
        end
        rd_q <= tap.rd_en;
        last_q <= tap.last;
    end

    // stage 2: multiply, act zero-extended to stay positive
    always_ff @(posedge clk) begin
        if (rd_q) begin
            prod_o <= $signed({1'b0, act_q}) * wght_q;
        end
        prod_valid_o <= rd_q;
        prod_last_o <= last_q;
    end

endmodule

/* logic/tap_sequencer.sv */
`timescale 1ns/100ps

module tap_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wght_valid_i,
    input  conv_types_pkg::wght_vec_t wght_i,
    output logic                      wght_ready_o,
    input  logic                      act_valid_i,
    input  conv_types_pkg::act_vec_t  act_i,
    output logic                      act_ready_o,
    tap_if.seq                        tap
);

    conv_types_pkg::seq_state_e state_q;
    conv_types_pkg::seq_state_e state_d;

    logic [conv_cfg_pkg::TAP_ADDR_W-1:0] tap_cnt_q;
    logic                                tap_wrap;
    logic                                wght_acc;
    logic                                act_acc;

    //////////////////////////////
    // handshake

    // compute phase takes weights only between windows
    assign wght_ready_o = (state_q != conv_types_pkg::ST_COMPUTE) || (tap_cnt_q == '0);
    assign wght_acc = wght_valid_i && wght_ready_o;

    assign act_ready_o = (state_q == conv_types_pkg::ST_COMPUTE) && !wght_acc;
    assign act_acc = act_valid_i && act_ready_o;

    assign tap_wrap = (tap_cnt_q == conv_cfg_pkg::LAST_TAP);

    //////////////////////////////
    // FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            conv_types_pkg::ST_IDLE: begin
                if (wght_acc) begin
                    state_d = conv_types_pkg::ST_W_LOAD;
                end
            end
            conv_types_pkg::ST_W_LOAD: begin
                if (wght_acc && tap_wrap) begin
                    state_d = conv_types_pkg::ST_COMPUTE;
                end
            end
            conv_types_pkg::ST_COMPUTE: begin
                if (wght_acc) begin
                    state_d = conv_types_pkg::ST_W_LOAD;    // reload at boundary
                end
            end
            default: state_d = conv_types_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= conv_types_pkg::ST_IDLE;
            tap_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // stalls just hold the count
            if (wght_acc || act_acc) begin
                tap_cnt_q <= tap_wrap ? '0 : tap_cnt_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // lane broadcast

    assign tap.wr_en = wght_acc;
    assign tap.rd_en = act_acc;
    assign tap.tap_addr = tap_cnt_q;
    assign tap.last = act_acc && tap_wrap;
    assign tap.wght = wght_i;
    assign tap.act = act_i;

endmodule

/* logic/tap_if.sv */
`timescale 1ns/100ps

// per-beat strobes and data broadcast to every lane
interface tap_if;

    logic                                wr_en;     // store weight at tap_addr
    logic                                rd_en;     // activation beat
    logic [conv_cfg_pkg::TAP_ADDR_W-1:0] tap_addr;
    logic                                last;      // final tap of window
    conv_types_pkg::wght_vec_t           wght;
    conv_types_pkg::act_vec_t            act;

    modport seq (
        output wr_en,
        output rd_en,
        output tap_addr,
        output last,
        output wght,
        output act
    );

    modport lane (
        input wr_en,
        input rd_en,
        input tap_addr,
        input last,
        input wght,
        input act
    );

endinterface

/* logic/conv_types_pkg.sv */
package conv_types_pkg;

    //////////////////////////////
    // scalar data
    typedef logic [conv_cfg_pkg::DATA_W-1:0] act_t;
    typedef logic signed [conv_cfg_pkg::DATA_W-1:0] wght_t;
    typedef logic signed [conv_cfg_pkg::PROD_W-1:0] prod_t;
    typedef logic signed [conv_cfg_pkg::ACC_W-1:0] acc_t;

    //////////////////////////////
    // one element per lane, lane 0 in the low bits
    typedef act_t [conv_cfg_pkg::LANES-1:0] act_vec_t;
    typedef wght_t [conv_cfg_pkg::LANES-1:0] wght_vec_t;
    typedef prod_t [conv_cfg_pkg::LANES-1:0] prod_vec_t;

    // sequencer FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_W_LOAD  = 2'd1,  // filling weight memories
        ST_COMPUTE = 2'd2
    } seq_state_e;

endpackage

/* logic/conv_cfg_pkg.sv */
package conv_cfg_pkg;

    //////////////////////////////
    // array geometry
    localparam int LANES = 8;       // input channels
    localparam int DATA_W = 8;
    localparam int TAPS = 9;        // 3x3 kernel
    localparam int TAP_ADDR_W = 4;

    //////////////////////////////
    // datapath widths
    localparam int PROD_W = 17;     // unsigned act x signed weight
    localparam int ACC_W = 24;

    // last kernel position, in counter width
    localparam logic [TAP_ADDR_W-1:0] LAST_TAP = TAP_ADDR_W'(TAPS - 1);

    //////////////////////////////
    // pipeline latencies
    localparam int TREE_STAGES = 3;
    localparam int LANE_LAT = 2;    // beat to registered product
    // lane + tree + accumulate
    localparam int RESULT_LAT = LANE_LAT + TREE_STAGES + 1;

endpackage
